// ==== verilog/div_consts.svh ====
// **************************************************
// divider constants
// operand width and the derived SRT step and
// leading-zero count widths
// **************************************************

`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// single operand width, even and a power of two
`define DIV_WIDTH 16

// radix-4 digits per division, two quotient bits each
`define DIV_DIGITS (`DIV_WIDTH / 2 + 1)

// a leading-zero count must hold the value DIV_WIDTH
`define DIV_LZC_W ($clog2(`DIV_WIDTH) + 1)

`endif

// ==== verilog/div_pkg.sv ====
// **************************************************
// div_pkg
// request, response and operand types shared by
// the divider blocks
// **************************************************

`include "div_consts.svh"

package div_pkg;

  typedef enum logic {
    ERR_ZERO = 1'b0, // divisor was zero
    ERR_OVF  = 1'b1  // quotient does not fit
  } div_err_e;

  typedef enum logic [2:0] {IDLE, PREP, ITER, FIX, DONE, ERROR} div_state_e;

  typedef struct packed {
    logic [2*`DIV_WIDTH-1:0] dividend;
    logic [`DIV_WIDTH-1:0]   divisor;
    logic                    signed_op;
  } div_req_t;

  typedef struct packed {
    logic [`DIV_WIDTH-1:0] quotient;
    logic [`DIV_WIDTH-1:0] remainder;
    logic                  error;
    div_err_e              err;
  } div_resp_t;

  // magnitudes shifted so the divisor msb is set
  typedef struct packed {
    logic [2*`DIV_WIDTH+1:0] dividend;
    logic [`DIV_WIDTH-1:0]   divisor;
    logic [`DIV_LZC_W-1:0]   shift;
    logic                    q_sign;
    logic                    r_sign;
    logic                    signed_op;
  } div_norm_t;

endpackage

// ==== verilog/div_lzc.sv ====
// **************************************************
// div_lzc
// leading-zero count of one operand word, built as
// a tree of halving zero checks
// **************************************************

`timescale 1ns/1ns
`include "div_consts.svh"

module div_lzc (
  input  logic [`DIV_WIDTH-1:0] val_i,
  output logic [`DIV_LZC_W-1:0] count_o
);

  localparam int W  = `DIV_WIDTH;
  localparam int LG = `DIV_LZC_W - 1;

  logic [W-1:0]  stage [LG+1];
  logic [LG-1:0] zbits; // one count bit per level

  assign stage[0] = val_i;

  // each level checks the upper half of what is left and shifts it out when zero
  for (genvar l = 0; l < LG; l++) begin : g_level
    localparam int CHUNK = W >> (l + 1);

    assign zbits[LG-1-l] = (stage[l][W-1 -: CHUNK] == '0);
    assign stage[l+1]    = zbits[LG-1-l] ? (stage[l] << CHUNK) : stage[l];
  end

  // msb still clear after all levels only for an all-zero word
  assign count_o = stage[LG][W-1] ? {1'b0, zbits} : {1'b1, {LG{1'b0}}};

endmodule

// ==== verilog/div_operand_prep.sv ====
// **************************************************
// div_operand_prep
// operand magnitudes, zero and overflow detection,
// normalization of divisor and dividend
// **************************************************

`timescale 1ns/1ns
`include "div_consts.svh"

module div_operand_prep
  import div_pkg::*;
(
  input  div_req_t  req_i,
  output div_norm_t norm_o,
  output logic      bad_o,
  output div_err_e  err_o
);

  localparam int W = `DIV_WIDTH;

  logic                  dvd_neg;
  logic                  dsr_neg;
  logic [2*W-1:0]        dvd_mag;
  logic [W-1:0]          dsr_mag;
  logic [`DIV_LZC_W-1:0] dsr_lz;
  logic [`DIV_LZC_W-1:0] hi_lz;
  logic                  dsr_zero;
  logic                  ovf;
  logic [2*W+1:0]        dvd_ext;

  assign dvd_neg = req_i.signed_op & req_i.dividend[2*W-1];
  assign dsr_neg = req_i.signed_op & req_i.divisor[W-1];

  assign dvd_mag = dvd_neg ? -req_i.dividend : req_i.dividend;
  assign dsr_mag = dsr_neg ? -req_i.divisor : req_i.divisor;

  div_lzc dsr_lzc_i (
    .val_i   (dsr_mag),
    .count_o (dsr_lz)
  );

  div_lzc hi_lzc_i (
    .val_i   (dvd_mag[2*W-1:W]),
    .count_o (hi_lz)
  );

  assign dsr_zero = (dsr_mag == '0);

  // upper half >= divisor means the quotient needs more than W bits
  // counts decide it unless both words start at the same bit
  assign ovf = (hi_lz < dsr_lz) |
               ((hi_lz == dsr_lz) & (dvd_mag[2*W-1:W] >= dsr_mag));

  assign bad_o = dsr_zero | ovf;
  assign err_o = dsr_zero ? ERR_ZERO : ERR_OVF; // zero divisor wins

  assign dvd_ext = {2'b00, dvd_mag};

  // same shift on both keeps the quotient, scales the remainder
  assign norm_o.dividend  = dvd_ext << dsr_lz;
  assign norm_o.divisor   = dsr_mag << dsr_lz;
  assign norm_o.shift     = dsr_lz;
  assign norm_o.q_sign    = dvd_neg ^ dsr_neg;
  assign norm_o.r_sign    = dvd_neg; // remainder follows the dividend
  assign norm_o.signed_op = req_i.signed_op;

endmodule

// ==== verilog/div_step_counter.sv ====
// **************************************************
// div_step_counter
// counts SRT digit steps down and flags the last
// **************************************************

`timescale 1ns/1ns
`include "div_consts.svh"

module div_step_counter (
  input  logic clk_i,
  input  logic reset_i,
  input  logic clear_i,
  input  logic en_i,
  output logic last_o
);

  localparam int CW = `DIV_LZC_W;

  logic [CW-1:0] cnt_r; // steps left after the current one

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r <= '0;
    end else if (clear_i) begin
      cnt_r <= CW'(`DIV_DIGITS - 1);
    end else if (en_i && (cnt_r != '0)) begin
      cnt_r <= cnt_r - 1'b1;
    end
  end

  // high during the final digit step
  assign last_o = en_i & (cnt_r == '0);

endmodule

// ==== verilog/div_srt_core.sv ====
// **************************************************
// div_srt_core
// radix-4 SRT recurrence, remainder kept as sum and
// carry words, digits -2..2 picked from a short
// estimate, quotient kept as plus and minus words
// **************************************************

`timescale 1ns/1ns
`include "div_consts.svh"

module div_srt_core
  import div_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  load_i,
  input  logic                  step_i,
  input  div_norm_t             norm_i,
  output logic [`DIV_WIDTH+2:0] rem_sum_o,
  output logic [`DIV_WIDTH+2:0] rem_carry_o,
  output logic [`DIV_WIDTH+1:0] q_pos_o,
  output logic [`DIV_WIDTH+1:0] q_neg_o
);

  localparam int W  = `DIV_WIDTH;
  localparam int RW = W + 3;
  localparam int QW = W + 2;

  logic [RW-1:0]     sum_r;
  logic [RW-1:0]     carry_r;
  logic [QW-1:0]     qp_r;
  logic [QW-1:0]     qn_r;
  logic [W+1:0]      low_r;    // dividend bits not yet shifted in
  logic [RW-1:0]     sum_sh;
  logic [RW-1:0]     carry_sh;
  logic [RW-1:0]     mult;
  logic [RW-1:0]     addend;
  logic [RW-1:0]     maj;
  logic signed [6:0] est;      // 3 integer and 4 fraction bits
  logic [27:0]       thr;
  logic signed [6:0] m2, m1, m0, mn1;
  logic [1:0]        q_mag;
  logic              q_is_neg;

  // 4w plus the next two dividend bits, kept in carry-save form
  assign sum_sh   = {sum_r[RW-3:0], low_r[W+1:W]};
  assign carry_sh = {carry_r[RW-3:0], 2'b00};

  assign est = sum_sh[RW-1 -: 7] + carry_sh[RW-1 -: 7];

  // selection constants in 1/16 steps, per divisor interval
  always_comb begin
    case (norm_i.divisor[W-2:W-4])
      3'd0:    thr = {7'sd12, 7'sd4, -7'sd4, -7'sd13};
      3'd1:    thr = {7'sd14, 7'sd4, -7'sd6, -7'sd15};
      3'd2:    thr = {7'sd15, 7'sd4, -7'sd6, -7'sd16};
      3'd3:    thr = {7'sd16, 7'sd4, -7'sd6, -7'sd18};
      3'd4:    thr = {7'sd18, 7'sd6, -7'sd8, -7'sd20};
      3'd5:    thr = {7'sd20, 7'sd6, -7'sd8, -7'sd20};
      3'd6:    thr = {7'sd20, 7'sd8, -7'sd8, -7'sd22};
      default: thr = {7'sd24, 7'sd8, -7'sd8, -7'sd24};
    endcase
  end

  assign m2  = thr[27:21];
  assign m1  = thr[20:14];
  assign m0  = thr[13:7];
  assign mn1 = thr[6:0];

  always_comb begin
    q_is_neg = 1'b0;
    if (est >= m2) begin
      q_mag = 2'd2;
    end else if (est >= m1) begin
      q_mag = 2'd1;
    end else if (est >= m0) begin
      q_mag = 2'd0;
    end else begin
      q_is_neg = 1'b1;
      q_mag    = (est >= mn1) ? 2'd1 : 2'd2;
    end
  end

  always_comb begin
    case (q_mag)
      2'd1:    mult = {3'b000, norm_i.divisor};
      2'd2:    mult = {2'b00, norm_i.divisor, 1'b0};
      default: mult = '0;
    endcase
  end

  // positive digit subtracts, so invert here and add one through the carry lsb
  assign addend = (!q_is_neg && (q_mag != 2'd0)) ? ~mult : mult;
  assign maj    = (sum_sh & carry_sh) | (sum_sh & addend) | (carry_sh & addend);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sum_r   <= '0;
      carry_r <= '0;
      qp_r    <= '0;
      qn_r    <= '0;
    end else if (load_i) begin
      sum_r   <= {3'b000, norm_i.dividend[2*W+1:W+2]};
      carry_r <= '0;
      qp_r    <= '0;
      qn_r    <= '0;
    end else if (step_i) begin
      sum_r   <= sum_sh ^ carry_sh ^ addend;
      carry_r <= {maj[RW-2:0], !q_is_neg && (q_mag != 2'd0)};
      qp_r    <= {qp_r[QW-3:0], q_is_neg ? 2'd0 : q_mag};
      qn_r    <= {qn_r[QW-3:0], q_is_neg ? q_mag : 2'd0};
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      low_r <= norm_i.dividend[W+1:0];
    end else if (step_i) begin
      low_r <= {low_r[W-1:0], 2'b00};
    end
  end

  assign rem_sum_o   = sum_r;
  assign rem_carry_o = carry_r;
  assign q_pos_o     = qp_r;
  assign q_neg_o     = qn_r;

endmodule

// ==== verilog/div_result_fix.sv ====
// **************************************************
// div_result_fix
// resolves remainder and quotient, corrects a
// negative remainder, denormalizes and signs
// **************************************************

`timescale 1ns/1ns
`include "div_consts.svh"

module div_result_fix
  import div_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  en_i,
  input  logic [`DIV_WIDTH+2:0] rem_sum_i,
  input  logic [`DIV_WIDTH+2:0] rem_carry_i,
  input  logic [`DIV_WIDTH+1:0] q_pos_i,
  input  logic [`DIV_WIDTH+1:0] q_neg_i,
  input  div_norm_t             norm_i,
  output div_resp_t             resp_o,
  output logic                  range_err_o
);

  localparam int W  = `DIV_WIDTH;
  localparam int RW = W + 3;
  localparam int QW = W + 2;

  logic          second_r;  // high in the second fix cycle
  logic [RW-1:0] rem_full;
  logic [QW-1:0] quo_full;
  logic [RW-1:0] rem_corr;
  logic [QW-1:0] quo_corr;
  logic [W-1:0]  rem_r;
  logic [W-1:0]  quo_r;
  logic [W-1:0]  rem_shift;
  div_resp_t     resp_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      second_r <= 1'b0;
    end else begin
      second_r <= en_i & ~second_r;
    end
  end

  assign rem_full = rem_sum_i + rem_carry_i;
  assign quo_full = q_pos_i - q_neg_i;

  // a negative remainder means the last digit overshot by one
  assign rem_corr = rem_full[RW-1] ? rem_full + {3'b000, norm_i.divisor} : rem_full;
  assign quo_corr = rem_full[RW-1] ? quo_full - 1'b1 : quo_full;

  always_ff @(posedge clk_i) begin
    if (en_i && !second_r) begin
      rem_r <= rem_corr[W-1:0];
      quo_r <= quo_corr[W-1:0];
    end
  end

  assign rem_shift = rem_r >> norm_i.shift; // undo normalization

  // magnitude fits W bits, the signed range is one bit narrower
  assign range_err_o = norm_i.signed_op &
                       (norm_i.q_sign ? (quo_r[W-1] & (|quo_r[W-2:0])) : quo_r[W-1]);

  always_ff @(posedge clk_i) begin
    if (en_i && second_r) begin
      resp_r.quotient  <= norm_i.q_sign ? -quo_r : quo_r;
      resp_r.remainder <= norm_i.r_sign ? -rem_shift : rem_shift;
      resp_r.error     <= range_err_o;
      resp_r.err       <= ERR_OVF;
    end
  end

  assign resp_o = resp_r;

endmodule

// ==== verilog/div_ctrl.sv ====
// **************************************************
// div_ctrl
// FSM sequencing accept, prep, digit steps and the
// two fix cycles, then holding until yumi
// **************************************************

`timescale 1ns/1ns

module div_ctrl
  import div_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       v_i,
  input  logic       yumi_i,
  input  logic       bad_i,
  input  logic       last_i,
  input  logic       range_err_i,
  output div_state_e state_o,
  output logic       load_req_o,
  output logic       core_load_o,
  output logic       step_en_o,
  output logic       fix_en_o
);

  div_state_e state_r;
  div_state_e state_nx;
  logic       fix_second_r;

  always_comb begin
    state_nx = state_r;
    case (state_r)
      IDLE: begin
        if (v_i) begin
          state_nx = PREP;
        end
      end
      PREP:  state_nx = bad_i ? ERROR : ITER;
      ITER: begin
        if (last_i) begin
          state_nx = FIX;
        end
      end
      FIX: begin
        if (fix_second_r) begin
          state_nx = range_err_i ? ERROR : DONE; // signed range checked here
        end
      end
      DONE, ERROR: begin
        if (yumi_i) begin
          state_nx = IDLE;
        end
      end
      default: state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r      <= IDLE;
      fix_second_r <= 1'b0;
    end else begin
      state_r      <= state_nx;
      fix_second_r <= (state_r == FIX) & ~fix_second_r;
    end
  end

  assign state_o     = state_r;
  assign load_req_o  = (state_r == IDLE) & v_i;   // accept
  assign core_load_o = (state_r == PREP) & ~bad_i;
  assign step_en_o   = (state_r == ITER);
  assign fix_en_o    = (state_r == FIX);

endmodule

// ==== verilog/div_top.sv ====
// **************************************************
// div_top
// radix-4 SRT integer divider with v/ready/yumi
// handshake, one division in flight
// **************************************************

`timescale 1ns/1ns
`include "div_consts.svh"

module div_top
  import div_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      v_i,
  input  logic      yumi_i,
  input  div_req_t  req_i,
  output logic      ready_o,
  output logic      v_o,
  output logic      error_o,
  output div_resp_t resp_o
);

  div_req_t                 req_r;
  div_err_e                 err_r;       // type of a prep error
  logic                     prep_bad_r;  // prep rejected the operands
  div_err_e                 prep_err;
  div_state_e               state;
  div_norm_t                norm;
  div_resp_t                fix_resp;
  logic                     bad, last, range_err;
  logic                     load_req, core_load, step_en, fix_en;
  logic [`DIV_WIDTH+2:0]    rem_sum, rem_carry;
  logic [`DIV_WIDTH+1:0]    q_pos, q_neg;

  always_ff @(posedge clk_i) begin
    if (load_req) begin
      req_r <= req_i;
    end
  end

  // prep errors keep their own type and later ones take the fix stage's
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_r      <= ERR_ZERO;
      prep_bad_r <= 1'b0;
    end else if (state == PREP) begin
      err_r      <= prep_err;
      prep_bad_r <= bad;
    end
  end

  div_ctrl ctrl_i (
    .clk_i(clk_i), .reset_i(reset_i), .v_i(v_i), .yumi_i(yumi_i),
    .bad_i(bad), .last_i(last), .range_err_i(range_err),
    .state_o(state), .load_req_o(load_req), .core_load_o(core_load),
    .step_en_o(step_en), .fix_en_o(fix_en)
  );

  div_step_counter step_cnt_i (
    .clk_i(clk_i), .reset_i(reset_i), .clear_i(core_load), .en_i(step_en), .last_o(last)
  );

  div_operand_prep prep_i (.req_i(req_r), .norm_o(norm), .bad_o(bad), .err_o(prep_err));

  div_srt_core core_i (
    .clk_i(clk_i), .reset_i(reset_i), .load_i(core_load), .step_i(step_en), .norm_i(norm),
    .rem_sum_o(rem_sum), .rem_carry_o(rem_carry), .q_pos_o(q_pos), .q_neg_o(q_neg)
  );

  div_result_fix fix_i (
    .clk_i(clk_i), .reset_i(reset_i), .en_i(fix_en),
    .rem_sum_i(rem_sum), .rem_carry_i(rem_carry), .q_pos_i(q_pos), .q_neg_i(q_neg),
    .norm_i(norm), .resp_o(fix_resp), .range_err_o(range_err)
  );

  assign ready_o = (state == IDLE);
  assign v_o     = (state == DONE);
  assign error_o = (state == ERROR);

  assign resp_o.quotient  = fix_resp.quotient;
  assign resp_o.remainder = fix_resp.remainder;
  assign resp_o.error     = prep_bad_r ? error_o : fix_resp.error;
  assign resp_o.err       = prep_bad_r ? err_r : fix_resp.err;

endmodule

// ==== verif/tb_clock_gen.sv ====
// **************************************************
// tb_clock_gen
// 10 ns testbench clock and a synchronous reset
// held high for the first 8 cycles
// **************************************************

`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

  always #5 clk_o = ~clk_o;

endmodule

// ==== verif/div_tb.sv ====
// **************************************************
// div_tb
// testbench for the SRT divider with a directed
// table and random operations against a
// wide-integer model, plus handshake, hold and
// latency checks
// **************************************************

`timescale 1ns/1ns
`include "div_consts.svh"

module div_tb
  import div_pkg::*;
();

  localparam int W          = `DIV_WIDTH;
  localparam int LAT_PREP   = 2;           // bad operands leave right after prep
  localparam int LAT_CORE   = W / 2 + 5;
  localparam int N_DIR      = 16;
  localparam int N_RAND     = 200;
  localparam int MAX_CYCLES = (N_DIR + N_RAND) * (W / 2 + 5 + 8) + 500;

  // one operation with everything expected from it
  typedef struct packed {
    logic [2*W-1:0] dividend;
    logic [W-1:0]   divisor;
    logic           signed_op;
    logic [W-1:0]   quotient;
    logic [W-1:0]   remainder;
    logic           error;
    div_err_e       err;
    logic [7:0]     latency;
  } vec_t;

  logic      clk_i;
  logic      reset_i;
  logic      v_i;
  logic      yumi_i;
  logic      ready_o;
  logic      v_o;
  logic      error_o;
  div_req_t  req_i;
  div_resp_t resp_o;

  vec_t   tbl [N_DIR];
  integer seed;
  int     errors;
  int     ops;
  int     cycles = 0;

  tb_clock_gen clk_gen_i (.clk_o(clk_i), .reset_o(reset_i));

  div_top div_top_i (
    .clk_i(clk_i), .reset_i(reset_i), .v_i(v_i), .yumi_i(yumi_i), .req_i(req_i),
    .ready_o(ready_o), .v_o(v_o), .error_o(error_o), .resp_o(resp_o)
  );

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("done: %0d operations, %0d errors", ops, errors + 1);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic set_row(input int idx, input logic [2*W-1:0] dvd, input logic [W-1:0] dsr,
                         input logic sgn, input logic [W-1:0] q, input logic [W-1:0] r,
                         input logic err, input div_err_e typ, input int lat);
    tbl[idx] = '{dvd, dsr, sgn, q, r, err, typ, 8'(lat)};
  endtask

  // q and r are don't care on error rows
  task automatic load_table();
    set_row(0, 100, 7, 1'b0, 14, 2, 1'b0, ERR_ZERO, LAT_CORE);
    set_row(1, 65535, 1, 1'b0, 65535, 0, 1'b0, ERR_ZERO, LAT_CORE);
    set_row(2, 32'hFFFE0001, 16'hFFFF, 1'b0, 16'hFFFF, 0, 1'b0, ERR_ZERO, LAT_CORE);
    set_row(3, 65536, 1, 1'b0, 0, 0, 1'b1, ERR_OVF, LAT_PREP);
    set_row(4, 1234, 0, 1'b0, 0, 0, 1'b1, ERR_ZERO, LAT_PREP);
    set_row(5, -7, 2, 1'b1, -3, -1, 1'b0, ERR_ZERO, LAT_CORE);
    set_row(6, 7, -2, 1'b1, -3, 1, 1'b0, ERR_ZERO, LAT_CORE);
    set_row(7, -7, -2, 1'b1, 3, -1, 1'b0, ERR_ZERO, LAT_CORE);
    set_row(8, -32768, 1, 1'b1, -32768, 0, 1'b0, ERR_ZERO, LAT_CORE);
    set_row(9, -32768, -1, 1'b1, 0, 0, 1'b1, ERR_OVF, LAT_CORE);
    set_row(10, 32767, 1, 1'b1, 32767, 0, 1'b0, ERR_ZERO, LAT_CORE);
    set_row(11, 65536, 2, 1'b1, 0, 0, 1'b1, ERR_OVF, LAT_CORE);
    set_row(12, -65536, 2, 1'b1, -32768, 0, 1'b0, ERR_ZERO, LAT_CORE);
    set_row(13, 32'h80000000, -1, 1'b1, 0, 0, 1'b1, ERR_OVF, LAT_PREP);
    set_row(14, -5, 0, 1'b1, 0, 0, 1'b1, ERR_ZERO, LAT_PREP);
    set_row(15, -1000000, 37, 1'b1, -27027, -1, 1'b0, ERR_ZERO, LAT_CORE);
  endtask

  // truncating division on magnitudes with the remainder signed like the dividend
  function automatic vec_t reference_divide(input div_req_t req);
    vec_t            v;
    logic            n_neg;
    logic            d_neg;
    logic            q_neg;
    longint unsigned nm;
    longint unsigned dm;
    longint unsigned qm;
    longint unsigned rm;
    v = '{req.dividend, req.divisor, req.signed_op, '0, '0, 1'b0, ERR_ZERO, 8'(LAT_CORE)};
    n_neg = req.signed_op & req.dividend[2*W-1];
    d_neg = req.signed_op & req.divisor[W-1];
    q_neg = n_neg ^ d_neg;
    nm = n_neg ? (64'd1 << (2 * W)) - 64'(req.dividend) : 64'(req.dividend);
    dm = d_neg ? (64'd1 << W) - 64'(req.divisor) : 64'(req.divisor);
    if (dm == 0) begin
      v.error   = 1'b1;
      v.latency = 8'(LAT_PREP);
    end else begin
      qm = nm / dm;
      rm = nm % dm;
      if (qm >= (64'd1 << W)) begin
        v.error   = 1'b1;
        v.err     = ERR_OVF;
        v.latency = 8'(LAT_PREP);
      end else if (req.signed_op &&
                   (q_neg ? (qm > (64'd1 << (W - 1))) : (qm >= (64'd1 << (W - 1))))) begin
        v.error = 1'b1;                  // caught after the core, in the fix stage
        v.err   = ERR_OVF;
      end else begin
        v.quotient  = W'(q_neg ? -qm : qm);
        v.remainder = W'(n_neg ? -rm : rm);
      end
    end
    return v;
  endfunction

  task automatic check_result(input vec_t exp, input int cyc);
    if (exp.error) begin
      if (!error_o || v_o) begin
        report_mismatch($sformatf("v_o %b error_o %b, expected an error for %h / %h",
                                  v_o, error_o, exp.dividend, exp.divisor));
      end
      if (resp_o.err !== exp.err) begin
        report_mismatch($sformatf("error type %s, expected %s for %h / %h",
                                  resp_o.err.name(), exp.err.name(), exp.dividend, exp.divisor));
      end
    end else begin
      if (!v_o || error_o) begin
        report_mismatch($sformatf("v_o %b error_o %b, expected a result for %h / %h",
                                  v_o, error_o, exp.dividend, exp.divisor));
      end
      if (resp_o.quotient !== exp.quotient || resp_o.remainder !== exp.remainder) begin
        report_mismatch($sformatf("q %h r %h, expected q %h r %h for %h / %h signed %b",
                                  resp_o.quotient, resp_o.remainder, exp.quotient,
                                  exp.remainder, exp.dividend, exp.divisor, exp.signed_op));
      end
    end
    if (resp_o.error !== exp.error) begin
      report_mismatch($sformatf("resp_o.error %b, expected %b for %h / %h",
                                resp_o.error, exp.error, exp.dividend, exp.divisor));
    end
    if (cyc != int'(exp.latency)) begin
      report_mismatch($sformatf("response after %0d cycles, expected %0d", cyc, exp.latency));
    end
  endtask

  // one full handshake from request through back-pressure to yumi
  task automatic run_division(input vec_t exp, input int hold, input logic poke);
    int        cyc;
    logic      done;
    div_resp_t held;
    div_req_t  junk;
    junk = {~exp.dividend, ~exp.divisor, exp.signed_op};
    @(posedge clk_i);
    v_i   <= 1'b1;
    req_i <= {exp.dividend, exp.divisor, exp.signed_op};
    @(posedge clk_i);                    // accept edge
    v_i <= 1'b0;
    cyc  = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      cyc++;
      if (v_o || error_o) begin
        done = 1'b1;
      end else begin
        if (ready_o) begin
          report_mismatch("ready_o high while a division is in flight");
        end
        if (poke && cyc == 3) begin
          @(posedge clk_i);
          v_i   <= 1'b1;                 // must be ignored while busy
          req_i <= junk;
        end else if (poke && cyc == 4) begin
          @(posedge clk_i);
          v_i <= 1'b0;
        end
      end
    end
    ops++;
    check_result(exp, cyc);
    held = resp_o;
    for (int h = 0; h < hold; h++) begin
      @(posedge clk_i);
      if (poke && h == 0) begin
        v_i   <= 1'b1;
        req_i <= junk;
      end
      @(negedge clk_i);
      if (resp_o !== held || ready_o || !(v_o || error_o)) begin
        report_mismatch("response changed or ready_o rose before yumi_i");
      end
    end
    @(posedge clk_i);
    yumi_i <= 1'b1;
    v_i    <= 1'b0;
    @(posedge clk_i);
    yumi_i <= 1'b0;
    @(negedge clk_i);
    if (!ready_o || v_o || error_o) begin
      report_mismatch("divider not back in idle after yumi_i");
    end
  endtask

  initial begin
    div_req_t       req;
    vec_t           exp;
    logic [2*W-1:0] raw;
    int             sel;
    int             shift;
    seed   = 32'h94a4cab6;
    errors = 0;
    ops    = 0;
    v_i    = 1'b0;
    yumi_i = 1'b0;
    req_i  = '0;
    load_table();
    @(negedge clk_i);
    while (reset_i) @(negedge clk_i);
    if (!ready_o || v_o || error_o) begin
      report_mismatch("outputs not idle after reset");
    end

    for (int i = 0; i < N_DIR; i++) begin
      run_division(tbl[i], i % 4, (i % 3) == 1);
    end

    for (int i = 0; i < N_RAND; i++) begin
      raw   = (2 * W)'({$random(seed), $random(seed)});
      sel   = $random(seed) & 7;
      shift = $random(seed) & (2 * W - 1);
      req.divisor   = W'($random(seed));
      req.signed_op = 1'($random(seed));
      req.dividend  = (sel == 1) ? raw : raw >> shift;  // a shifted dividend often fits
      if (sel == 0) begin
        req.divisor = '0;
      end else if (sel == 2) begin
        req.divisor = W'(($random(seed) & 7) + 1);
      end
      if (req.signed_op && ($random(seed) & 1)) begin
        req.dividend = -req.dividend;
      end
      exp = reference_divide(req);
      run_division(exp, $random(seed) & 3, (i % 5) == 0);
    end

    $display("done: %0d operations, %0d errors", ops, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/div_pkg.sv
verilog/div_lzc.sv
verilog/div_operand_prep.sv
verilog/div_step_counter.sv
verilog/div_srt_core.sv
verilog/div_result_fix.sv
verilog/div_ctrl.sv
verilog/div_top.sv
verif/tb_clock_gen.sv
verif/div_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the divider testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module div_tb -f sources.f \
  --Mdir obj_dir -o div_sim

./obj_dir/div_sim > sim.log
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation reported errors, see sim.log"
  exit 1
fi
echo "simulation finished without errors"
